// ==== hw/exu_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_alu #(
    parameter int XLEN = 64
) (
    input wire exu_pkg::exu_op_e op,
    input wire [XLEN-1:0] imm,
    input wire [XLEN-1:0] pc,
    input wire [XLEN-1:0] src1,
    input wire [XLEN-1:0] src2,
    output logic [XLEN-1:0] alu_result,
    output logic [XLEN-1:0] link,
    output logic [XLEN-1:0] dnpc
);

    localparam int SHAMT_W = $clog2(XLEN);

    exu_pkg::alu_mode_e mode;
    logic [XLEN-1:0] opnd_a;
    logic [XLEN-1:0] opnd_b;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0] br_target;
    logic br_taken;

    // operand a is pc only for jal
    assign opnd_a = (op == exu_pkg::OP_JAL) ? pc : src1;

    always_comb begin
        case (op)
            exu_pkg::OP_SLL, exu_pkg::OP_SRL, exu_pkg::OP_SRA:
                opnd_b = {{(XLEN-SHAMT_W){1'b0}}, src2[SHAMT_W-1:0]};
            exu_pkg::OP_ADDI, exu_pkg::OP_JAL, exu_pkg::OP_JALR:
                opnd_b = imm;
            default:
                // loads and stores add the offset too
                opnd_b = exu_pkg::is_mem(op) ? imm : src2;
        endcase
    end

    assign shamt = opnd_b[SHAMT_W-1:0];

    // everything not listed is an add
    always_comb begin
        case (op)
            exu_pkg::OP_SUB:  mode = exu_pkg::ALU_SUB;
            exu_pkg::OP_AND:  mode = exu_pkg::ALU_AND;
            exu_pkg::OP_OR:   mode = exu_pkg::ALU_OR;
            exu_pkg::OP_XOR:  mode = exu_pkg::ALU_XOR;
            exu_pkg::OP_SLL:  mode = exu_pkg::ALU_SLL;
            exu_pkg::OP_SRL:  mode = exu_pkg::ALU_SRL;
            exu_pkg::OP_SRA:  mode = exu_pkg::ALU_SRA;
            exu_pkg::OP_SLT:  mode = exu_pkg::ALU_SLT;
            exu_pkg::OP_SLTU: mode = exu_pkg::ALU_SLTU;
            default:          mode = exu_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        case (mode)
            exu_pkg::ALU_SUB:  alu_result = opnd_a - opnd_b;
            exu_pkg::ALU_AND:  alu_result = opnd_a & opnd_b;
            exu_pkg::ALU_OR:   alu_result = opnd_a | opnd_b;
            exu_pkg::ALU_XOR:  alu_result = opnd_a ^ opnd_b;
            exu_pkg::ALU_SLL:  alu_result = opnd_a << shamt;
            exu_pkg::ALU_SRL:  alu_result = opnd_a >> shamt;
            exu_pkg::ALU_SRA:  alu_result = $signed(opnd_a) >>> shamt;
            exu_pkg::ALU_SLT:  alu_result = XLEN'($signed(opnd_a) < $signed(opnd_b));
            exu_pkg::ALU_SLTU: alu_result = XLEN'(opnd_a < opnd_b);
            default:           alu_result = opnd_a + opnd_b;
        endcase
    end

    // branch compare straight on the sources
    always_comb begin
        case (op)
            exu_pkg::OP_BEQ: br_taken = (src1 == src2);
            exu_pkg::OP_BNE: br_taken = (src1 != src2);
            exu_pkg::OP_BLT: br_taken = ($signed(src1) < $signed(src2));
            exu_pkg::OP_BGE: br_taken = ($signed(src1) >= $signed(src2));
            default:         br_taken = 1'b0;
        endcase
    end

    assign link = pc + XLEN'(4);
    assign br_target = pc + imm;

    always_comb begin
        if (op == exu_pkg::OP_JAL || br_taken) begin
            dnpc = br_target;
        end else if (op == exu_pkg::OP_JALR) begin
            dnpc = {alu_result[XLEN-1:1], 1'b0};
        end else begin
            dnpc = link;
        end
        // jalr never lands on an odd address
        if (op == exu_pkg::OP_JALR) begin
            assert (!dnpc[0])
                else $error("jalr target %h is odd", dnpc);
        end
    end

endmodule

`default_nettype wire

// ==== hw/exu_lsu.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_lsu #(
    parameter int XLEN = 64,
    parameter int ADDR_W = 32
) (
    input wire clk,
    input wire rst,
    input wire exu_pkg::exu_op_e op,
    input wire [XLEN-1:0] src2,
    input wire [XLEN-1:0] alu_result,
    output logic arvalid,
    output logic [ADDR_W-1:0] araddr,
    input wire arready,
    input wire rvalid,
    input wire [XLEN-1:0] rdata,
    output logic rready,
    output logic awvalid,
    output logic [ADDR_W-1:0] awaddr,
    input wire awready,
    output logic wvalid,
    output logic [XLEN-1:0] wdata,
    output logic [XLEN/exu_pkg::BYTE_W-1:0] wstrb,
    input wire wready,
    input wire bvalid,
    output logic bready,
    output logic [XLEN-1:0] load_data,
    output logic mem_done
);

    localparam int LANES = XLEN / exu_pkg::BYTE_W;
    localparam int OFF_W = $clog2(LANES);

    exu_pkg::lsu_state_e state;
    logic [ADDR_W-1:0] addr_q;
    logic [OFF_W-1:0] addr_off;
    logic [OFF_W-1:0] off_q;
    logic [1:0] size;
    logic [LANES-1:0] strb_base;
    logic aligned;
    logic ar_left;
    logic aw_left;
    logic w_left;
    logic [XLEN-1:0] rd_shift;

    assign addr_off = alu_result[OFF_W-1:0];
    assign size = exu_pkg::mem_size(op);
    // offset must be a multiple of the access size
    assign aligned = (addr_off & OFF_W'((1 << size) - 1)) == '0;

    always_comb begin
        case (size)
            exu_pkg::SZ_B: strb_base = LANES'(1);
            exu_pkg::SZ_H: strb_base = LANES'(3);
            exu_pkg::SZ_W: strb_base = LANES'(15);
            default:       strb_base = '1;
        endcase
    end

    // channels still waiting for their handshake
    assign ar_left = arvalid && !arready;
    assign aw_left = awvalid && !awready;
    assign w_left = wvalid && !wready;

    assign mem_done = (rvalid && rready) || (bvalid && bready);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= exu_pkg::LSU_IDLE;
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            rready <= 1'b0;
            bready <= 1'b0;
        end else begin
            case (state)
                exu_pkg::LSU_IDLE: begin
                    if (exu_pkg::is_mem(op)) begin
                        state <= exu_pkg::LSU_REQ;
                        arvalid <= exu_pkg::is_load(op);
                        awvalid <= exu_pkg::is_store(op);
                        wvalid <= exu_pkg::is_store(op);
                    end
                end
                exu_pkg::LSU_REQ: begin
                    // each valid drops on its own handshake
                    if (arready) arvalid <= 1'b0;
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if (!ar_left && !aw_left && !w_left) begin
                        state <= exu_pkg::LSU_RESP;
                        rready <= exu_pkg::is_load(op);
                        bready <= exu_pkg::is_store(op);
                    end
                end
                exu_pkg::LSU_RESP: begin
                    if (mem_done) begin
                        state <= exu_pkg::LSU_IDLE;
                        rready <= 1'b0;
                        bready <= 1'b0;
                    end
                end
                default: state <= exu_pkg::LSU_IDLE;
            endcase
        end
    end

    // request payload, captured once per op
    always_ff @(posedge clk) begin
        if (state == exu_pkg::LSU_IDLE && exu_pkg::is_mem(op)) begin
            addr_q <= alu_result[ADDR_W-1:0];
            off_q <= addr_off;
            wdata <= src2 << (addr_off * exu_pkg::BYTE_W);
            wstrb <= strb_base << addr_off;
        end
    end

    assign araddr = addr_q;
    assign awaddr = addr_q;

    // addressed lane moved down to bit 0
    assign rd_shift = rdata >> (off_q * exu_pkg::BYTE_W);

    always_comb begin
        case (op)
            exu_pkg::OP_LB:  load_data = {{(XLEN-8){rd_shift[7]}}, rd_shift[7:0]};
            exu_pkg::OP_LH:  load_data = {{(XLEN-16){rd_shift[15]}}, rd_shift[15:0]};
            exu_pkg::OP_LW:  load_data = {{(XLEN-32){rd_shift[31]}}, rd_shift[31:0]};
            exu_pkg::OP_LBU: load_data = {{(XLEN-8){1'b0}}, rd_shift[7:0]};
            exu_pkg::OP_LHU: load_data = {{(XLEN-16){1'b0}}, rd_shift[15:0]};
            exu_pkg::OP_LWU: load_data = {{(XLEN-32){1'b0}}, rd_shift[31:0]};
            default:         load_data = rd_shift;
        endcase
    end

    assert property (@(posedge clk) disable iff (rst)
        state == exu_pkg::LSU_IDLE && exu_pkg::is_mem(op) |-> aligned)
        else $error("misaligned access at %h", alu_result);

    // address held until the slave takes it
    assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr));

    assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr));

    assert property (@(posedge clk) disable iff (rst)
        state == exu_pkg::LSU_IDLE |-> !mem_done);

endmodule

`default_nettype wire

// ==== hw/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

    // decoded opcodes, OP_NONE is a bubble
    typedef enum logic [4:0] {
        OP_NONE, OP_LUI,
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU, OP_ADDI,
        OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
        OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
        OP_SB, OP_SH, OP_SW, OP_SD
    } exu_op_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_mode_e;

    typedef enum logic [1:0] {
        LSU_IDLE, LSU_REQ, LSU_RESP
    } lsu_state_e;

    localparam int REG_ADDR_W = 5;
    localparam int REG_NUM = 32;

    // one bus lane per byte
    localparam int BYTE_W = 8;

    // log2 of access size in bytes
    localparam logic [1:0] SZ_B = 2'd0;
    localparam logic [1:0] SZ_H = 2'd1;
    localparam logic [1:0] SZ_W = 2'd2;
    localparam logic [1:0] SZ_D = 2'd3;

    function automatic logic is_load(exu_op_e op);
        return op inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};
    endfunction

    function automatic logic is_store(exu_op_e op);
        return op inside {OP_SB, OP_SH, OP_SW, OP_SD};
    endfunction

    function automatic logic is_mem(exu_op_e op);
        return is_load(op) || is_store(op);
    endfunction

    function automatic logic [1:0] mem_size(exu_op_e op);
        if (op inside {OP_LB, OP_LBU, OP_SB}) return SZ_B;
        if (op inside {OP_LH, OP_LHU, OP_SH}) return SZ_H;
        if (op inside {OP_LW, OP_LWU, OP_SW}) return SZ_W;
        return SZ_D;
    endfunction

endpackage

`default_nettype wire

// ==== hw/exu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_top #(
    parameter int XLEN = 64,
    parameter int ADDR_W = 32
) (
    input wire clk,
    input wire rst,
    // decoded instruction, held while stall is high
    input wire exu_pkg::exu_op_e op,
    input wire [exu_pkg::REG_ADDR_W-1:0] rd,
    input wire [exu_pkg::REG_ADDR_W-1:0] rs1,
    input wire [exu_pkg::REG_ADDR_W-1:0] rs2,
    input wire [XLEN-1:0] imm,
    input wire [XLEN-1:0] pc,
    output wire [XLEN-1:0] dnpc,
    output wire pc_update,
    output wire stall,
    // read address and data
    output wire arvalid,
    output wire [ADDR_W-1:0] araddr,
    input wire arready,
    input wire rvalid,
    input wire [XLEN-1:0] rdata,
    output wire rready,
    // write address, data and response
    output wire awvalid,
    output wire [ADDR_W-1:0] awaddr,
    input wire awready,
    output wire wvalid,
    output wire [XLEN-1:0] wdata,
    output wire [XLEN/exu_pkg::BYTE_W-1:0] wstrb,
    input wire wready,
    input wire bvalid,
    output wire bready
);

    wire [XLEN-1:0] src1;
    wire [XLEN-1:0] src2;
    wire [XLEN-1:0] alu_result;
    wire [XLEN-1:0] link;
    wire [XLEN-1:0] load_data;
    wire mem_done;

    // alu result doubles as the load/store address
    exu_alu #(
        .XLEN(XLEN)
    ) exu_alu_i (.*);

    exu_lsu #(
        .XLEN(XLEN),
        .ADDR_W(ADDR_W)
    ) exu_lsu_i (.*);

    // owns the register file and the stall level
    exu_writeback #(
        .XLEN(XLEN)
    ) exu_writeback_i (.*);

endmodule

`default_nettype wire

// ==== hw/exu_writeback.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_writeback #(
    parameter int XLEN = 64
) (
    input wire clk,
    input wire rst,
    input wire exu_pkg::exu_op_e op,
    input wire [exu_pkg::REG_ADDR_W-1:0] rd,
    input wire [exu_pkg::REG_ADDR_W-1:0] rs1,
    input wire [exu_pkg::REG_ADDR_W-1:0] rs2,
    input wire [XLEN-1:0] imm,
    input wire [XLEN-1:0] alu_result,
    input wire [XLEN-1:0] link,
    input wire [XLEN-1:0] load_data,
    input wire mem_done,
    output logic [XLEN-1:0] src1,
    output logic [XLEN-1:0] src2,
    output logic stall,
    output logic pc_update
);

    logic [XLEN-1:0] regs [exu_pkg::REG_NUM];
    logic [XLEN-1:0] wb_data;
    logic op_writes;
    logic wen;

    // x0 reads as zero
    assign src1 = (rs1 == '0) ? '0 : regs[rs1];
    assign src2 = (rs2 == '0) ? '0 : regs[rs2];

    always_comb begin
        wb_data = alu_result;
        op_writes = 1'b1;
        case (op)
            exu_pkg::OP_LUI: wb_data = imm;
            exu_pkg::OP_JAL, exu_pkg::OP_JALR: wb_data = link;
            exu_pkg::OP_NONE, exu_pkg::OP_BEQ, exu_pkg::OP_BNE,
            exu_pkg::OP_BLT, exu_pkg::OP_BGE: op_writes = 1'b0;
            default: begin
                // stores write nothing, loads take the extended data
                if (exu_pkg::is_store(op)) op_writes = 1'b0;
                if (exu_pkg::is_load(op)) wb_data = load_data;
            end
        endcase
    end

    // hold upstream until the bus response lands
    assign stall = exu_pkg::is_mem(op) && !mem_done;
    assign pc_update = (op != exu_pkg::OP_NONE) && !stall;
    assign wen = op_writes && (rd != '0) && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < exu_pkg::REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[rd] <= wb_data;
        end
    end

    assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
        else $error("x0 was written");

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the simulation from verilog.f and run it; pass only when TEST OK appears
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module exu_tb -o exu_sim &&
./obj_dir/exu_sim | grep "TEST OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== sim/exu_ref.svh ====
`ifndef EXU_REF_SVH
`define EXU_REF_SVH

// model state of the register file and memory, memory indexed by 8-byte word
logic [63:0] model_regs [32];
logic [63:0] model_mem [int];

// 16-bit fibonacci lfsr, taps 16 14 13 11, one step per bit
function automatic logic [63:0] take_bits(input int n, inout logic [15:0] s);
    logic [63:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        s = {s[14:0], fb};
        v = {v[62:0], fb};
    end
    return v;
endfunction

// untouched words hold a pattern made from the full word index
function automatic logic [63:0] mem_fill(input int widx);
    return {~widx, widx ^ 32'h5a5a_0000};
endfunction

function automatic logic [63:0] model_word(input int widx);
    return model_mem.exists(widx) ? model_mem[widx] : mem_fill(widx);
endfunction

function automatic int access_bytes(input exu_pkg::exu_op_e op);
    case (op)
        exu_pkg::OP_LB, exu_pkg::OP_LBU, exu_pkg::OP_SB: return 1;
        exu_pkg::OP_LH, exu_pkg::OP_LHU, exu_pkg::OP_SH: return 2;
        exu_pkg::OP_LW, exu_pkg::OP_LWU, exu_pkg::OP_SW: return 4;
        default: return 8;
    endcase
endfunction

function automatic logic store_op(input exu_pkg::exu_op_e op);
    return op == exu_pkg::OP_SB || op == exu_pkg::OP_SH ||
        op == exu_pkg::OP_SW || op == exu_pkg::OP_SD;
endfunction

function automatic logic load_op(input exu_pkg::exu_op_e op);
    return op >= exu_pkg::OP_LB && op <= exu_pkg::OP_LWU;
endfunction

// branches, stores and bubbles leave the registers alone
function automatic logic writes_reg(input exu_pkg::exu_op_e op);
    return !(op == exu_pkg::OP_NONE || store_op(op) ||
        (op >= exu_pkg::OP_BEQ && op <= exu_pkg::OP_BGE));
endfunction

function automatic logic [7:0] exp_strb(input exu_pkg::exu_op_e op, input logic [63:0] addr);
    return 8'((1 << access_bytes(op)) - 1) << addr[2:0];
endfunction

function automatic logic [63:0] exp_wdata(input logic [63:0] addr, input logic [63:0] b);
    return b << (addr[2:0] * 8);
endfunction

// byte strobe widened to a bit mask
function automatic logic [63:0] byte_mask(input logic [7:0] strb);
    logic [63:0] m;
    for (int i = 0; i < 8; i++) begin
        m[i*8 +: 8] = {8{strb[i]}};
    end
    return m;
endfunction

function automatic logic [63:0] exp_dnpc(input exu_pkg::exu_op_e op,
        input logic [63:0] pc, input logic [63:0] imm,
        input logic [63:0] a, input logic [63:0] b);
    case (op)
        exu_pkg::OP_JAL:  return pc + imm;
        exu_pkg::OP_JALR: return (a + imm) & ~64'd1;
        exu_pkg::OP_BEQ:  return (a == b) ? pc + imm : pc + 4;
        exu_pkg::OP_BNE:  return (a != b) ? pc + imm : pc + 4;
        exu_pkg::OP_BLT:  return ($signed(a) < $signed(b)) ? pc + imm : pc + 4;
        exu_pkg::OP_BGE:  return ($signed(a) >= $signed(b)) ? pc + imm : pc + 4;
        default:          return pc + 4;
    endcase
endfunction

function automatic logic [63:0] exp_reg(input exu_pkg::exu_op_e op,
        input logic [63:0] pc, input logic [63:0] imm,
        input logic [63:0] a, input logic [63:0] b);
    logic [63:0] addr;
    logic [63:0] w;
    addr = a + imm;
    // addressed bytes moved down to bit 0
    w = model_word(int'(addr[31:3])) >> (addr[2:0] * 8);
    case (op)
        exu_pkg::OP_LUI:  return imm;
        exu_pkg::OP_ADD:  return a + b;
        exu_pkg::OP_SUB:  return a - b;
        exu_pkg::OP_AND:  return a & b;
        exu_pkg::OP_OR:   return a | b;
        exu_pkg::OP_XOR:  return a ^ b;
        exu_pkg::OP_SLL:  return a << b[5:0];
        exu_pkg::OP_SRL:  return a >> b[5:0];
        exu_pkg::OP_SRA:  return $signed(a) >>> b[5:0];
        exu_pkg::OP_SLT:  return {63'd0, $signed(a) < $signed(b)};
        exu_pkg::OP_SLTU: return {63'd0, a < b};
        exu_pkg::OP_ADDI: return a + imm;
        exu_pkg::OP_JAL, exu_pkg::OP_JALR: return pc + 4;
        exu_pkg::OP_LB:   return {{56{w[7]}}, w[7:0]};
        exu_pkg::OP_LH:   return {{48{w[15]}}, w[15:0]};
        exu_pkg::OP_LW:   return {{32{w[31]}}, w[31:0]};
        exu_pkg::OP_LBU:  return {56'd0, w[7:0]};
        exu_pkg::OP_LHU:  return {48'd0, w[15:0]};
        exu_pkg::OP_LWU:  return {32'd0, w[31:0]};
        default:          return w;
    endcase
endfunction

`endif

// ==== sim/exu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_tb;

    localparam int STALL_MAX = 60;
    localparam int IDLE_MAX = 20000;

    logic clk;
    logic rst;
    exu_pkg::exu_op_e op;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [63:0] imm;
    logic [63:0] pc;
    wire [63:0] dnpc;
    wire pc_update;
    wire stall;
    wire arvalid;
    wire [31:0] araddr;
    logic arready;
    logic rvalid;
    logic [63:0] rdata;
    wire rready;
    wire awvalid;
    wire [31:0] awaddr;
    logic awready;
    wire wvalid;
    wire [63:0] wdata;
    wire [7:0] wstrb;
    logic wready;
    logic bvalid;
    wire bready;

    `include "exu_ref.svh"

    // bus side memory kept apart from the model
    logic [63:0] bus_mem [int];
    logic [15:0] data_lfsr;
    logic [15:0] dly_lfsr;
    logic delay_en;
    logic [63:0] next_pc;
    logic [63:0] sig;
    int mism_errs;
    int other_errs;
    int req_cnt;
    int mem_ops;

    // stores expected by the model and stores seen on the bus
    logic [31:0] exp_addr [$];
    logic [63:0] exp_data [$];
    logic [7:0] exp_strbs [$];
    logic [31:0] got_addr [$];
    logic [63:0] got_data [$];
    logic [7:0] got_strb [$];

    exu_pkg::exu_op_e alu_ops [11] = '{exu_pkg::OP_ADD, exu_pkg::OP_SUB, exu_pkg::OP_AND,
        exu_pkg::OP_OR, exu_pkg::OP_XOR, exu_pkg::OP_SLL, exu_pkg::OP_SRL, exu_pkg::OP_SRA,
        exu_pkg::OP_SLT, exu_pkg::OP_SLTU, exu_pkg::OP_ADDI};
    exu_pkg::exu_op_e ld_ops [7] = '{exu_pkg::OP_LB, exu_pkg::OP_LH, exu_pkg::OP_LW,
        exu_pkg::OP_LD, exu_pkg::OP_LBU, exu_pkg::OP_LHU, exu_pkg::OP_LWU};
    exu_pkg::exu_op_e br_ops [4] = '{exu_pkg::OP_BEQ, exu_pkg::OP_BNE, exu_pkg::OP_BLT,
        exu_pkg::OP_BGE};

    exu_top #(
        .XLEN(64),
        .ADDR_W(32)
    ) exu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("TEST FAILED");
        $finish;
    endtask

    // at posedge+2 on entry and exit
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    function automatic int pick_delay();
        return delay_en ? int'(take_bits(2, dly_lfsr)) : 0;
    endfunction

    function automatic logic [63:0] bus_word(input int widx);
        return bus_mem.exists(widx) ? bus_mem[widx] : mem_fill(widx);
    endfunction

    // 8-byte memory behind the bus with random ready and response delays
    initial begin : responder
        int idle;
        int n;
        logic [31:0] a;
        logic [63:0] wd;
        logic [7:0] ws;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        forever begin
            idle = 0;
            @(negedge clk);
            while (!(arvalid || awvalid)) begin
                idle++;
                if (idle > IDLE_MAX) give_up("a bus request");
                @(negedge clk);
            end
            req_cnt++;
            a = arvalid ? araddr : awaddr;
            wd = wdata;
            ws = wstrb;
            // store data comes up with its address
            if (awvalid) begin
                assert (wvalid) else begin
                    other_errs++;
                    $display("write data not valid together with the write address");
                end
            end
            @(posedge clk);
            #2;
            wait_cycles(pick_delay());
            if (arvalid) begin
                arready = 1'b1;
                wait_cycles(1);
                arready = 1'b0;
                wait_cycles(pick_delay());
                rvalid = 1'b1;
                rdata = bus_word(int'(a[31:3]));
                n = 0;
                while (!rready) begin
                    n++;
                    if (n > STALL_MAX) give_up("rready");
                    wait_cycles(1);
                end
                wait_cycles(1);
                rvalid = 1'b0;
            end else begin
                awready = 1'b1;
                wready = 1'b1;
                wait_cycles(1);
                awready = 1'b0;
                wready = 1'b0;
                wait_cycles(pick_delay());
                bvalid = 1'b1;
                n = 0;
                while (!bready) begin
                    n++;
                    if (n > STALL_MAX) give_up("bready");
                    wait_cycles(1);
                end
                wait_cycles(1);
                bvalid = 1'b0;
                // merge the strobed bytes
                bus_mem[int'(a[31:3])] = (bus_word(int'(a[31:3])) & ~byte_mask(ws)) |
                    (wd & byte_mask(ws));
                got_addr.push_back(a);
                got_data.push_back(wd);
                got_strb.push_back(ws);
                sig = {sig[62:0], sig[63]} ^ (wd & byte_mask(ws)) ^ 64'(a);
            end
        end
    end

    // compares each store seen on the bus against the model
    always @(negedge clk) begin : compare
        logic [31:0] ga;
        logic [31:0] ea;
        logic [63:0] gd;
        logic [63:0] ed;
        logic [7:0] gs;
        logic [7:0] es;
        while (got_addr.size() > 0) begin
            ga = got_addr.pop_front();
            gd = got_data.pop_front();
            gs = got_strb.pop_front();
            assert (exp_addr.size() > 0) else begin
                other_errs++;
                $display("store to %h seen on the bus but none was issued", ga);
            end
            if (exp_addr.size() > 0) begin
                ea = exp_addr.pop_front();
                ed = exp_data.pop_front();
                es = exp_strbs.pop_front();
                assert (ga === ea) else begin
                    mism_errs++;
                    $display("MISMATCH awaddr got %h exp %h", ga, ea);
                end
                assert (gs === es) else begin
                    mism_errs++;
                    $display("MISMATCH wstrb got %h exp %h", gs, es);
                end
                // only the strobed lanes carry data
                assert ((gd & byte_mask(es)) === (ed & byte_mask(es))) else begin
                    mism_errs++;
                    $display("MISMATCH wdata got %h exp %h", gd, ed);
                end
            end
        end
    end

    task automatic issue(input exu_pkg::exu_op_e o, input logic [4:0] d,
            input logic [4:0] s1, input logic [4:0] s2, input logic [63:0] im);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] e_pc;
        logic [63:0] e_reg;
        logic [63:0] addr;
        logic [63:0] m;
        int n;
        a = model_regs[s1];
        b = model_regs[s2];
        addr = a + im;
        e_pc = exp_dnpc(o, next_pc, im, a, b);
        e_reg = exp_reg(o, next_pc, im, a, b);
        if (store_op(o)) begin
            exp_addr.push_back(addr[31:0]);
            exp_data.push_back(exp_wdata(addr, b));
            exp_strbs.push_back(exp_strb(o, addr));
            m = byte_mask(exp_strb(o, addr));
            model_mem[int'(addr[31:3])] = (model_word(int'(addr[31:3])) & ~m) |
                (exp_wdata(addr, b) & m);
        end
        if (store_op(o) || load_op(o)) mem_ops++;
        @(posedge clk);
        #2;
        op = o;
        rd = d;
        rs1 = s1;
        rs2 = s2;
        imm = im;
        pc = next_pc;
        n = 0;
        @(negedge clk);
        while (stall) begin
            assert (!pc_update) else begin
                other_errs++;
                $display("pc_update high while stalled on %s", o.name());
            end
            // read address while the request is pending
            if (load_op(o) && arvalid) begin
                assert (araddr === addr[31:0]) else begin
                    mism_errs++;
                    $display("MISMATCH araddr got %h exp %h", araddr, addr[31:0]);
                end
            end
            n++;
            if (n > STALL_MAX) give_up("stall to drop");
            @(negedge clk);
        end
        if (store_op(o) || load_op(o)) begin
            assert ((rvalid && rready) || (bvalid && bready)) else begin
                other_errs++;
                $display("stall dropped before the response handshake on %s", o.name());
            end
        end
        assert (pc_update) else begin
            other_errs++;
            $display("pc_update low after %s completed", o.name());
        end
        assert (dnpc === e_pc) else begin
            mism_errs++;
            $display("MISMATCH dnpc got %h exp %h (%s)", dnpc, e_pc, o.name());
        end
        if (writes_reg(o) && d != 0) model_regs[d] = e_reg;
        next_pc = e_pc;
    endtask

    // full instruction sequence from reset that returns the store signature
    task automatic run_program(input logic delays, output logic [63:0] result);
        logic [63:0] w;
        int step;
        delay_en = delays;
        data_lfsr = 16'd7;
        dly_lfsr = 16'd7;
        sig = '0;
        req_cnt = 0;
        mem_ops = 0;
        next_pc = 64'h1000;
        model_mem.delete();
        bus_mem.delete();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        @(posedge clk);
        #2;
        rst = 1'b1;
        op = exu_pkg::OP_NONE;
        wait_cycles(5);
        rst = 1'b0;
        @(negedge clk);
        assert (!arvalid && !awvalid && !wvalid && !rready && !bready && !stall && !pc_update)
            else begin
                other_errs++;
                $display("bus or stall outputs not low after reset");
            end
        // random words behind addresses 0x100..0x17f
        for (int i = 0; i < 16; i++) begin
            w = take_bits(64, data_lfsr);
            model_mem[32 + i] = w;
            bus_mem[32 + i] = w;
        end
        issue(exu_pkg::OP_LUI, 1, 0, 0, take_bits(64, data_lfsr));
        issue(exu_pkg::OP_ADDI, 2, 0, 0, take_bits(64, data_lfsr));
        for (int i = 0; i < 11; i++) begin
            issue(alu_ops[i], 5, 1, 2, take_bits(64, data_lfsr));
            issue(exu_pkg::OP_SD, 0, 0, 5, 64'h200 + 64'(i * 8));
            issue(alu_ops[i], 5, 2, 1, take_bits(64, data_lfsr));
            issue(exu_pkg::OP_SD, 0, 0, 5, 64'h280 + 64'(i * 8));
        end
        // every aligned lane of one word
        for (int off = 0; off < 8; off++) begin
            issue(exu_pkg::OP_SB, 0, 0, 1, 64'h300 + 64'(off));
        end
        for (int off = 0; off < 8; off += 2) begin
            issue(exu_pkg::OP_SH, 0, 0, 2, 64'h308 + 64'(off));
        end
        for (int off = 0; off < 8; off += 4) begin
            issue(exu_pkg::OP_SW, 0, 0, 1, 64'h310 + 64'(off));
        end
        for (int i = 0; i < 7; i++) begin
            step = access_bytes(ld_ops[i]);
            for (int off = 0; off < 8; off += step) begin
                w = 64'h100 + (take_bits(4, data_lfsr) << 3) + 64'(off);
                issue(ld_ops[i], 6, 0, 0, w);
                issue(exu_pkg::OP_SD, 0, 0, 6, 64'h400);
            end
        end
        issue(exu_pkg::OP_JAL, 7, 0, 0, 64'h40);
        issue(exu_pkg::OP_SD, 0, 0, 7, 64'h500);
        issue(exu_pkg::OP_JALR, 8, 1, 0, take_bits(64, data_lfsr));
        issue(exu_pkg::OP_SD, 0, 0, 8, 64'h508);
        // equal then unequal both ways
        for (int i = 0; i < 4; i++) begin
            issue(br_ops[i], 0, 1, 1, 64'h20);
            issue(br_ops[i], 0, 1, 2, -64'sd16);
            issue(br_ops[i], 0, 2, 1, 64'h48);
        end
        @(posedge clk);
        #2;
        op = exu_pkg::OP_NONE;
        wait_cycles(3);
        assert (req_cnt == mem_ops) else begin
            other_errs++;
            $display("%0d bus requests for %0d memory ops", req_cnt, mem_ops);
        end
        assert (exp_addr.size() == 0) else begin
            other_errs++;
            $display("%0d issued stores never reached the bus", exp_addr.size());
        end
        result = sig;
    endtask

    initial begin : main
        logic [63:0] sig_fast;
        logic [63:0] sig_slow;
        rst = 1'b1;
        op = exu_pkg::OP_NONE;
        rd = '0;
        rs1 = '0;
        rs2 = '0;
        imm = '0;
        pc = '0;
        mism_errs = 0;
        other_errs = 0;
        run_program(1'b0, sig_fast);
        run_program(1'b1, sig_slow);
        assert (sig_fast === sig_slow) else begin
            mism_errs++;
            $display("MISMATCH store signature got %h exp %h", sig_slow, sig_fast);
        end
        $display("errors: %0d mismatches, %0d other", mism_errs, other_errs);
        if (mism_errs == 0 && other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+sim
hw/exu_pkg.sv
hw/exu_alu.sv
hw/exu_lsu.sv
hw/exu_writeback.sv
hw/exu_top.sv
sim/exu_tb.sv
